/* run_sim.sh */
#!/bin/sh
# Compile and run the RV32I core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_rv_core \
    -Mdir obj_dir -o sim_rv_core
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/sim_rv_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH PASSED" sim.log; then
    exit 0
fi
exit 1

/* sources.f */
src/rv_pkg.sv
src/rv_fetch.sv
src/rv_regfile.sv
src/rv_decode.sv
src/rv_execute.sv
src/rv_result.sv
src/rv_core_top.sv
verification/rv_core_sva.sv
verification/rv_retire_checker.sv
verification/tb_rv_core.sv

/* src/rv_core_top.sv */
// Top level of the four-stage RV32I core, fetch, decode, execute and
// result wired together
`timescale 1ns/1ps

module rv_core_top import rv_pkg::*; #(
    parameter int IMEM_WORDS = 256
) (
    input  logic                          i_clk,
    input  logic                          i_reset,
    // Instruction memory load port
    input  logic                          i_imem_we,
    input  logic [$clog2(IMEM_WORDS)-1:0] i_imem_addr,
    input  word_t                         i_imem_wdata,
    // Retire trace
    output logic                          o_insn_vld,
    output word_t                         o_pc_debug,
    output logic                          o_rd_wren,
    output reg_addr_t                     o_rd_addr,
    output word_t                         o_rd_data
);

    fetch_pkt_t  fetch_pkt;
    exec_pkt_t   exec_pkt;
    result_pkt_t result_pkt;
    wb_pkt_t     wb_pkt;
    redirect_t   redirect;
    logic        stall;

    rv_fetch #(
        .IMEM_WORDS (IMEM_WORDS)
    ) rv_fetch_i (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_imem_we    (i_imem_we),
        .i_imem_addr  (i_imem_addr),
        .i_imem_wdata (i_imem_wdata),
        .i_stall      (stall),
        .i_redirect   (redirect),
        .o_fetch      (fetch_pkt)
    );

    rv_decode rv_decode_i (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_fetch    (fetch_pkt),
        .i_wb       (wb_pkt),
        .i_redirect (redirect),
        .o_stall    (stall),
        .o_exec     (exec_pkt)
    );

    // Combinational, redirect feeds fetch and decode
    rv_execute rv_execute_i (
        .i_exec     (exec_pkt),
        .o_result   (result_pkt),
        .o_redirect (redirect)
    );

    rv_result rv_result_i (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_result   (result_pkt),
        .o_wb       (wb_pkt),
        .o_insn_vld (o_insn_vld),
        .o_pc_debug (o_pc_debug),
        .o_rd_wren  (o_rd_wren),
        .o_rd_addr  (o_rd_addr),
        .o_rd_data  (o_rd_data)
    );

endmodule

/* src/rv_decode.sv */
// Control decode, immediate generation, RAW hazard stall and the
// decode-to-execute register
`timescale 1ns/1ps

module rv_decode import rv_pkg::*; (
    input  logic       i_clk,
    input  logic       i_reset,
    input  fetch_pkt_t i_fetch,
    input  wb_pkt_t    i_wb,
    input  redirect_t  i_redirect,
    output logic       o_stall,
    output exec_pkt_t  o_exec
);

    word_t      inst;
    logic [6:0] opcode;
    logic [2:0] funct3;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    word_t      rs1_data;
    word_t      rs2_data;
    logic       uses_rs1;
    logic       uses_rs2;
    logic       hazard_rs1;
    logic       hazard_rs2;
    exec_pkt_t  exec_d;
    exec_pkt_t  exec_q;

    assign inst   = i_fetch.inst;
    assign opcode = inst[6:0];
    assign funct3 = inst[FUNCT3_LSB +: 3];
    assign rs1    = inst[RS1_LSB +: 5];
    assign rs2    = inst[RS2_LSB +: 5];

    rv_regfile rv_regfile_i (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_rs1      (rs1),
        .i_rs2      (rs2),
        .i_wb       (i_wb),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    //======================================================================
    // Control and immediate
    //======================================================================
    always_comb begin
        exec_d           = '0;
        exec_d.valid     = i_fetch.valid;
        exec_d.pc        = i_fetch.pc;
        exec_d.rs1_data  = rs1_data;
        exec_d.rs2_data  = rs2_data;
        exec_d.rd        = inst[RD_LSB +: 5];
        exec_d.funct3    = funct3;
        exec_d.alu_op    = ALU_ADD;
        uses_rs1         = 1'b0;
        uses_rs2         = 1'b0;
        case (opcode)
            OP_RTYPE, OP_ITYPE: begin
                exec_d.rd_wren = 1'b1;
                uses_rs1       = 1'b1;
                uses_rs2       = (opcode == OP_RTYPE);
                exec_d.op2_imm = (opcode == OP_ITYPE);
                // I immediate, shamt sits in its low bits
                exec_d.imm     = {{20{inst[31]}}, inst[31:20]};
                case (funct3)
                    3'b000: begin
                        // SUB only exists in R-type
                        if ((opcode == OP_RTYPE) && inst[FUNCT7_B5]) begin
                            exec_d.alu_op = ALU_SUB;
                        end else begin
                            exec_d.alu_op = ALU_ADD;
                        end
                    end
                    3'b001:  exec_d.alu_op = ALU_SLL;
                    3'b010:  exec_d.alu_op = ALU_SLT;
                    3'b011:  exec_d.alu_op = ALU_SLTU;
                    3'b100:  exec_d.alu_op = ALU_XOR;
                    3'b101:  exec_d.alu_op = inst[FUNCT7_B5] ? ALU_SRA : ALU_SRL;
                    3'b110:  exec_d.alu_op = ALU_OR;
                    default: exec_d.alu_op = ALU_AND;
                endcase
            end
            OP_LUI: begin
                exec_d.rd_wren = 1'b1;
                exec_d.op2_imm = 1'b1;
                exec_d.alu_op  = ALU_PASS_B;
                exec_d.imm     = {inst[31:12], 12'b0};
            end
            OP_BRANCH: begin
                // ALU forms pc + imm for the target
                exec_d.is_branch = 1'b1;
                exec_d.op1_pc    = 1'b1;
                exec_d.op2_imm   = 1'b1;
                uses_rs1         = 1'b1;
                uses_rs2         = 1'b1;
                exec_d.imm       = {{19{inst[31]}}, inst[31], inst[7],
                                    inst[30:25], inst[11:8], 1'b0};
            end
            OP_JAL: begin
                exec_d.is_jal  = 1'b1;
                exec_d.rd_wren = 1'b1;
                exec_d.op1_pc  = 1'b1;
                exec_d.op2_imm = 1'b1;
                exec_d.imm     = {{11{inst[31]}}, inst[31], inst[19:12],
                                  inst[20], inst[30:21], 1'b0};
            end
            // Anything else retires as a no-op
            default: ;
        endcase
    end

    //======================================================================
    // Hazard check
    //======================================================================
    // Producers: own register and the writeback packet
    assign hazard_rs1 = uses_rs1 && (rs1 != 5'd0) &&
        ((exec_q.valid && exec_q.rd_wren && (exec_q.rd == rs1)) ||
         (i_wb.wren && (i_wb.rd == rs1)));
    assign hazard_rs2 = uses_rs2 && (rs2 != 5'd0) &&
        ((exec_q.valid && exec_q.rd_wren && (exec_q.rd == rs2)) ||
         (i_wb.wren && (i_wb.rd == rs2)));

    assign o_stall = i_fetch.valid && (hazard_rs1 || hazard_rs2);

    // Bubble on stall or redirect
    always_ff @(posedge i_clk) begin
        if (!i_reset || i_redirect.taken || o_stall) begin
            exec_q <= '0;
        end else begin
            exec_q <= exec_d;
        end
    end

    assign o_exec = exec_q;

endmodule

/* src/rv_execute.sv */
// Operand select, ALU, branch compare and redirect for the
// combinational execute stage
`timescale 1ns/1ps

module rv_execute import rv_pkg::*; (
    input  exec_pkt_t   i_exec,
    output result_pkt_t o_result,
    output redirect_t   o_redirect
);

    word_t op_a;
    word_t op_b;
    word_t alu_out;
    logic  br_eq;
    logic  br_lt;
    logic  br_ltu;
    logic  br_cond;

    //======================================================================
    // Operands and ALU
    //======================================================================
    // pc only for branch and JAL target
    assign op_a = i_exec.op1_pc  ? i_exec.pc  : i_exec.rs1_data;
    assign op_b = i_exec.op2_imm ? i_exec.imm : i_exec.rs2_data;

    always_comb begin
        case (i_exec.alu_op)
            ALU_ADD:    alu_out = op_a + op_b;
            ALU_SUB:    alu_out = op_a - op_b;
            ALU_AND:    alu_out = op_a & op_b;
            ALU_OR:     alu_out = op_a | op_b;
            ALU_XOR:    alu_out = op_a ^ op_b;
            // Shift amount is the low five bits
            ALU_SLL:    alu_out = op_a << op_b[4:0];
            ALU_SRL:    alu_out = op_a >> op_b[4:0];
            ALU_SRA:    alu_out = word_t'($signed(op_a) >>> op_b[4:0]);
            ALU_SLT:    alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_out = {31'b0, op_a < op_b};
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = '0;
        endcase
    end

    //======================================================================
    // Branch resolution
    //======================================================================
    // Always on the register operands
    assign br_eq  = (i_exec.rs1_data == i_exec.rs2_data);
    assign br_lt  = ($signed(i_exec.rs1_data) < $signed(i_exec.rs2_data));
    assign br_ltu = (i_exec.rs1_data < i_exec.rs2_data);

    always_comb begin
        case (i_exec.funct3)
            3'b000:  br_cond = br_eq;
            3'b001:  br_cond = !br_eq;
            3'b100:  br_cond = br_lt;
            // GE is simply not LT
            3'b101:  br_cond = !br_lt;
            3'b110:  br_cond = br_ltu;
            3'b111:  br_cond = !br_ltu;
            default: br_cond = 1'b0;
        endcase
    end

    // Target is the ALU sum pc + imm
    assign o_redirect.taken  = i_exec.valid &&
                               (i_exec.is_jal || (i_exec.is_branch && br_cond));
    assign o_redirect.target = alu_out;

    // Toward the result stage
    assign o_result.valid      = i_exec.valid;
    assign o_result.pc         = i_exec.pc;
    assign o_result.rd         = i_exec.rd;
    assign o_result.rd_wren    = i_exec.rd_wren;
    assign o_result.is_jal     = i_exec.is_jal;
    assign o_result.alu_result = alu_out;

endmodule

/* src/rv_fetch.sv */
// Program counter, instruction memory with a load port, and the
// fetch-to-decode pipeline register
`timescale 1ns/1ps

module rv_fetch import rv_pkg::*; #(
    parameter int IMEM_WORDS = 256
) (
    input  logic                          i_clk,
    input  logic                          i_reset,
    input  logic                          i_imem_we,
    input  logic [$clog2(IMEM_WORDS)-1:0] i_imem_addr,
    input  word_t                         i_imem_wdata,
    input  logic                          i_stall,
    input  redirect_t                     i_redirect,
    output fetch_pkt_t                    o_fetch
);

    localparam int AW = $clog2(IMEM_WORDS);

    word_t      imem [IMEM_WORDS];
    word_t      pc_q;
    word_t      inst;
    fetch_pkt_t fetch_q;

    // Load port, word index
    always_ff @(posedge i_clk) begin
        if (i_imem_we) begin
            imem[i_imem_addr] <= i_imem_wdata;
        end
    end

    // Asynchronous read at the pc word index
    assign inst = imem[pc_q[AW+1:2]];

    // Redirect first, then stall holds
    always_ff @(posedge i_clk) begin
        if (!i_reset) begin
            pc_q <= '0;
        end else if (i_redirect.taken) begin
            pc_q <= i_redirect.target;
        end else if (!i_stall) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    // Packet toward decode, dropped on redirect
    always_ff @(posedge i_clk) begin
        if (!i_reset || i_redirect.taken) begin
            fetch_q <= '0;
        end else if (!i_stall) begin
            fetch_q.valid <= 1'b1;
            fetch_q.pc    <= pc_q;
            fetch_q.inst  <= inst;
        end
    end

    assign o_fetch = fetch_q;

endmodule

/* src/rv_pkg.sv */
// Shared widths, opcode and ALU constants, and the stage-to-stage packet
// structs of the four-stage RV32I core
package rv_pkg;

    //======================================================================
    // Basic types
    //======================================================================
    // Instruction, pc, operand or result
    typedef logic [31:0] word_t;
    // Register index
    typedef logic [4:0]  reg_addr_t;
    // ALU operation select
    typedef logic [3:0]  alu_op_t;

    // ALU operations
    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_AND    = 4'd2;
    localparam alu_op_t ALU_OR     = 4'd3;
    localparam alu_op_t ALU_XOR    = 4'd4;
    localparam alu_op_t ALU_SLL    = 4'd5;
    localparam alu_op_t ALU_SRL    = 4'd6;
    localparam alu_op_t ALU_SRA    = 4'd7;
    localparam alu_op_t ALU_SLT    = 4'd8;
    localparam alu_op_t ALU_SLTU   = 4'd9;
    // Operand b straight through, for LUI
    localparam alu_op_t ALU_PASS_B = 4'd10;

    // Supported major opcodes
    localparam logic [6:0] OP_RTYPE  = 7'b0110011;
    localparam logic [6:0] OP_ITYPE  = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    // Field positions inside an instruction word
    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;
    // Picks SUB over ADD and SRA over SRL
    localparam int FUNCT7_B5  = 30;

    //======================================================================
    // Stage packets
    //======================================================================
    // Fetch to decode, 65 bits
    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t inst;
    } fetch_pkt_t;

    // Decode to execute
    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     rs1_data;
        word_t     rs2_data;
        word_t     imm;
        reg_addr_t rd;
        alu_op_t   alu_op;
        logic [2:0] funct3;
        logic      op1_pc;
        logic      op2_imm;
        logic      is_branch;
        logic      is_jal;
        logic      rd_wren;
    } exec_pkt_t;

    // Execute to result
    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t rd;
        logic      rd_wren;
        logic      is_jal;
        word_t     alu_result;
    } result_pkt_t;

    // Register write, also seen by the hazard check
    typedef struct packed {
        logic      wren;
        reg_addr_t rd;
        word_t     data;
    } wb_pkt_t;

    // Taken branch or jump from execute, 33 bits
    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

endpackage

/* src/rv_regfile.sv */
// 32 x 32 integer register file, two combinational reads and one
// synchronous write, x0 fixed at zero
`timescale 1ns/1ps

module rv_regfile import rv_pkg::*; (
    input  logic      i_clk,
    input  logic      i_reset,
    input  reg_addr_t i_rs1,
    input  reg_addr_t i_rs2,
    input  wb_pkt_t   i_wb,
    output word_t     o_rs1_data,
    output word_t     o_rs2_data
);

    word_t regs [32];

    // Write port, x0 never written
    always_ff @(posedge i_clk) begin
        if (!i_reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wb.wren && (i_wb.rd != 5'd0)) begin
            regs[i_wb.rd] <= i_wb.data;
        end
    end

    // Read ports
    // no bypass from the write port, decode stalls instead
    assign o_rs1_data = (i_rs1 == 5'd0) ? '0 : regs[i_rs1];
    assign o_rs2_data = (i_rs2 == 5'd0) ? '0 : regs[i_rs2];

endmodule

/* src/rv_result.sv */
// Execute-to-writeback register, write data select and the retire
// trace outputs
`timescale 1ns/1ps

module rv_result import rv_pkg::*; (
    input  logic        i_clk,
    input  logic        i_reset,
    input  result_pkt_t i_result,
    output wb_pkt_t     o_wb,
    output logic        o_insn_vld,
    output word_t       o_pc_debug,
    output logic        o_rd_wren,
    output reg_addr_t   o_rd_addr,
    output word_t       o_rd_data
);

    result_pkt_t res_q;

    always_ff @(posedge i_clk) begin
        if (!i_reset) begin
            res_q <= '0;
        end else begin
            res_q <= i_result;
        end
    end

    // Link address for JAL, x0 always reads back zero
    assign o_wb.wren = res_q.valid && res_q.rd_wren;
    assign o_wb.rd   = res_q.rd;
    assign o_wb.data = (res_q.rd == 5'd0) ? '0 :
                       res_q.is_jal       ? res_q.pc + 32'd4 : res_q.alu_result;

    // Retire trace, same cycle as the register write
    assign o_insn_vld = res_q.valid;
    assign o_pc_debug = res_q.pc;
    assign o_rd_wren  = o_wb.wren;
    assign o_rd_addr  = o_wb.rd;
    assign o_rd_data  = o_wb.data;

endmodule

/* verification/rv_core_sva.sv */
// Bound assertions on the retire trace, the redirect flush and the
// hazard stall
`timescale 1ns/1ps

module rv_core_sva import rv_pkg::*; (
    input logic      i_clk,
    input logic      i_reset,
    input redirect_t i_redirect,
    input exec_pkt_t i_exec,
    input logic      i_insn_vld,
    input logic      i_stall
);

    // Nothing retires in the cycle after a reset edge
    a_no_retire_in_reset: assert property (@(posedge i_clk)
        !i_reset |=> !i_insn_vld)
        else $error("retirement during reset");

    // Two bubbles reach execute after a taken redirect
    a_redirect_flush: assert property (@(posedge i_clk) disable iff (!i_reset)
        i_redirect.taken |=> !i_exec.valid ##1 !i_exec.valid)
        else $error("decode packet issued inside the redirect shadow");

    // Producer leaves writeback within two cycles, so the stall clears
    a_stall_bounded: assert property (@(posedge i_clk) disable iff (!i_reset)
        (i_stall && $past(i_stall)) |=> !i_stall)
        else $error("decode stall held longer than two cycles");

endmodule

bind rv_core_top rv_core_sva rv_core_sva_i (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_redirect (redirect),
    .i_exec     (exec_pkt),
    .i_insn_vld (o_insn_vld),
    .i_stall    (stall)
);

/* verification/rv_retire_checker.sv */
// Retire trace checker with the expected retirement table, per-group
// report lines and pass and error counters
`timescale 1ns/1ps

module rv_retire_checker import rv_pkg::*; #(
    parameter int N_ROWS = 29
) (
    input  logic      i_clk,
    input  logic      i_reset,
    input  logic      i_insn_vld,
    input  word_t     i_pc,
    input  logic      i_rd_wren,
    input  reg_addr_t i_rd_addr,
    input  word_t     i_rd_data,
    output int        o_rows_done,
    output int        o_pass_count,
    output int        o_err_count
);

    word_t     exp_pc   [N_ROWS];
    logic      exp_wren [N_ROWS];
    reg_addr_t exp_rd   [N_ROWS];
    word_t     exp_data [N_ROWS];
    int        exp_grp  [N_ROWS];
    int        fill;
    int        row;
    int        errs;
    int        passes;
    int        grp_errs;
    logic      row_ok;

    task automatic add_row(word_t pc, logic wren, reg_addr_t rd, word_t data, int grp);
        exp_pc[fill]   = pc;
        exp_wren[fill] = wren;
        exp_rd[fill]   = rd;
        exp_data[fill] = data;
        exp_grp[fill]  = grp;
        fill++;
    endtask

    function automatic string grp_name(int grp);
        case (grp)
            0:       return "alu and hazards";
            1:       return "branches";
            default: return "jal and x0";
        endcase
    endfunction

    task automatic compare(string name, word_t exp_v, word_t act_v);
        if (exp_v !== act_v) begin
            $display("error at %0t ns: %s expected %h got %h", $time, name, exp_v, act_v);
            row_ok = 1'b0;
        end
    endtask

    //======================================================================
    // Expected retirements, worked out by hand
    //======================================================================
    initial begin
        fill = 0;
        add_row(32'h00, 1'b1, 5'd1, 32'h0000_0005, 0);
        add_row(32'h04, 1'b1, 5'd2, 32'hffff_fffd, 0);
        add_row(32'h08, 1'b1, 5'd3, 32'h0000_0002, 0);
        add_row(32'h0c, 1'b1, 5'd4, 32'h0000_0008, 0);
        add_row(32'h10, 1'b1, 5'd5, 32'h0000_0001, 0);
        add_row(32'h14, 1'b1, 5'd6, 32'h0000_0000, 0);
        add_row(32'h18, 1'b1, 5'd7, 32'h0000_0028, 0);
        add_row(32'h1c, 1'b1, 5'd8, 32'hffff_fffe, 0);
        add_row(32'h20, 1'b1, 5'd9, 32'h0000_000f, 0);
        add_row(32'h24, 1'b1, 5'd10, 32'h1234_5000, 0);
        add_row(32'h28, 1'b1, 5'd11, 32'h1234_5005, 0);
        add_row(32'h2c, 1'b1, 5'd12, 32'h0000_000d, 0);
        add_row(32'h30, 1'b1, 5'd13, 32'h0000_00f0, 0);
        add_row(32'h34, 1'b1, 5'd0, 32'h0000_0000, 0);
        add_row(32'h38, 1'b1, 5'd14, 32'h0000_0005, 0);
        // Branches write nothing, rd and data not compared
        add_row(32'h3c, 1'b0, 5'd0, 32'h0, 1);
        add_row(32'h48, 1'b0, 5'd0, 32'h0, 1);
        add_row(32'h4c, 1'b0, 5'd0, 32'h0, 1);
        add_row(32'h58, 1'b0, 5'd0, 32'h0, 1);
        add_row(32'h64, 1'b0, 5'd0, 32'h0, 1);
        add_row(32'h68, 1'b0, 5'd0, 32'h0, 1);
        add_row(32'h74, 1'b0, 5'd0, 32'h0, 1);
        add_row(32'h78, 1'b0, 5'd0, 32'h0, 1);
        add_row(32'h84, 1'b0, 5'd0, 32'h0, 1);
        add_row(32'h88, 1'b0, 5'd0, 32'h0, 1);
        add_row(32'h94, 1'b0, 5'd0, 32'h0, 1);
        // Link is pc + 4, then the self loop on x0
        add_row(32'h98, 1'b1, 5'd15, 32'h0000_009c, 2);
        add_row(32'ha4, 1'b1, 5'd16, 32'h0000_009d, 2);
        add_row(32'ha8, 1'b1, 5'd0, 32'h0000_0000, 2);
    end

    initial begin
        row      = 0;
        errs     = 0;
        passes   = 0;
        grp_errs = 0;
    end

    always @(posedge i_clk) begin
        if (!i_reset) begin
            if (i_insn_vld) begin
                $display("retirement seen while reset is held at %0t ns", $time);
                errs++;
            end
        end else if (i_insn_vld && (row < N_ROWS)) begin
            row_ok = 1'b1;
            compare("o_pc_debug", exp_pc[row], i_pc);
            compare("o_rd_wren", 32'(exp_wren[row]), 32'(i_rd_wren));
            if (exp_wren[row]) begin
                compare("o_rd_addr", 32'(exp_rd[row]), 32'(i_rd_addr));
                compare("o_rd_data", exp_data[row], i_rd_data);
            end
            if (row_ok) begin
                passes++;
            end else begin
                errs++;
                grp_errs++;
            end
            // Group report once its last row has retired
            if ((row == N_ROWS - 1) || (exp_grp[row + 1] != exp_grp[row])) begin
                $display("test %s done, %0d errors", grp_name(exp_grp[row]), grp_errs);
                grp_errs = 0;
            end
            row++;
        end
        o_rows_done  <= row;
        o_pass_count <= passes;
        o_err_count  <= errs;
    end

endmodule

/* verification/tb_rv_core.sv */
// Testbench top for the RV32I core: clock, reset, program table loaded
// through the instruction memory port, retirement wait and final report
`timescale 1ns/1ps

module tb_rv_core import rv_pkg::*;;

    localparam int IMEM_WORDS = 256;
    localparam int N_ROWS     = 29;
    localparam int TIMEOUT    = 2000;

    logic       i_clk;
    logic       i_reset;
    logic       i_imem_we;
    logic [7:0] i_imem_addr;
    word_t      i_imem_wdata;
    logic       o_insn_vld;
    word_t      o_pc_debug;
    logic       o_rd_wren;
    reg_addr_t  o_rd_addr;
    word_t      o_rd_data;

    int    rows_done;
    int    pass_count;
    int    err_count;
    int    cycles;
    logic  timed_out;
    word_t prog [$];

    rv_core_top #(
        .IMEM_WORDS (IMEM_WORDS)
    ) rv_core_top_i (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_imem_we    (i_imem_we),
        .i_imem_addr  (i_imem_addr),
        .i_imem_wdata (i_imem_wdata),
        .o_insn_vld   (o_insn_vld),
        .o_pc_debug   (o_pc_debug),
        .o_rd_wren    (o_rd_wren),
        .o_rd_addr    (o_rd_addr),
        .o_rd_data    (o_rd_data)
    );

    rv_retire_checker #(
        .N_ROWS (N_ROWS)
    ) rv_retire_checker_i (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_insn_vld   (o_insn_vld),
        .i_pc         (o_pc_debug),
        .i_rd_wren    (o_rd_wren),
        .i_rd_addr    (o_rd_addr),
        .i_rd_data    (o_rd_data),
        .o_rows_done  (rows_done),
        .o_pass_count (pass_count),
        .o_err_count  (err_count)
    );

    // 8 ns period
    always #4 i_clk = ~i_clk;

    //======================================================================
    // Instruction encoders, straight from the RV32I formats
    //======================================================================
    function automatic word_t enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                    logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t enc_i(logic [11:0] imm, logic [4:0] rs1,
                                    logic [2:0] f3, logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic word_t enc_u(logic [19:0] imm, logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    // Branch offset in bytes, bit 0 dropped
    function automatic word_t enc_b(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
                                    logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic word_t enc_j(logic [20:0] off, logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // Two skipped slots after a taken branch, writes x31 if ever retired
    task automatic add_poison();
        prog.push_back(enc_i(12'd1, 5'd0, 3'b000, 5'd31));
        prog.push_back(enc_i(12'd2, 5'd0, 3'b000, 5'd31));
    endtask

    task automatic build_program();
        // ALU, LUI and back-to-back hazards, pc 0x00 to 0x38
        prog.push_back(enc_i(12'd5, 5'd0, 3'b000, 5'd1));
        prog.push_back(enc_i(12'hffd, 5'd0, 3'b000, 5'd2));
        prog.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
        prog.push_back(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd4));
        prog.push_back(enc_r(7'h00, 5'd1, 5'd2, 3'b010, 5'd5));
        prog.push_back(enc_r(7'h00, 5'd1, 5'd2, 3'b011, 5'd6));
        prog.push_back(enc_i(12'd3, 5'd1, 3'b001, 5'd7));
        prog.push_back(enc_i(12'h401, 5'd2, 3'b101, 5'd8));
        prog.push_back(enc_i(12'd28, 5'd2, 3'b101, 5'd9));
        prog.push_back(enc_u(20'h12345, 5'd10));
        prog.push_back(enc_r(7'h00, 5'd1, 5'd10, 3'b100, 5'd11));
        prog.push_back(enc_r(7'h00, 5'd4, 5'd1, 3'b110, 5'd12));
        prog.push_back(enc_i(12'h0f0, 5'd2, 3'b111, 5'd13));
        prog.push_back(enc_i(12'd7, 5'd1, 3'b000, 5'd0));
        prog.push_back(enc_r(7'h00, 5'd1, 5'd0, 3'b000, 5'd14));
        // Branches, taken ones jump over two poison slots
        prog.push_back(enc_b(13'd12, 5'd1, 5'd1, 3'b000));
        add_poison();
        prog.push_back(enc_b(13'd8, 5'd1, 5'd1, 3'b001));
        prog.push_back(enc_b(13'd12, 5'd2, 5'd1, 3'b001));
        add_poison();
        prog.push_back(enc_b(13'd12, 5'd1, 5'd2, 3'b100));
        add_poison();
        prog.push_back(enc_b(13'd8, 5'd2, 5'd1, 3'b100));
        prog.push_back(enc_b(13'd12, 5'd2, 5'd1, 3'b101));
        add_poison();
        prog.push_back(enc_b(13'd8, 5'd1, 5'd2, 3'b101));
        prog.push_back(enc_b(13'd12, 5'd2, 5'd1, 3'b110));
        add_poison();
        prog.push_back(enc_b(13'd8, 5'd1, 5'd2, 3'b110));
        prog.push_back(enc_b(13'd12, 5'd1, 5'd2, 3'b111));
        add_poison();
        prog.push_back(enc_b(13'd8, 5'd2, 5'd1, 3'b111));
        // JAL with link, then a reader of the link register
        prog.push_back(enc_j(21'd12, 5'd15));
        add_poison();
        prog.push_back(enc_i(12'd1, 5'd15, 3'b000, 5'd16));
        // Park on a self loop, padded with nops
        prog.push_back(enc_j(21'd0, 5'd0));
        prog.push_back(enc_i(12'd0, 5'd0, 3'b000, 5'd0));
        prog.push_back(enc_i(12'd0, 5'd0, 3'b000, 5'd0));
    endtask

    initial begin
        i_clk        = 1'b0;
        i_reset      = 1'b0;
        i_imem_we    = 1'b0;
        i_imem_addr  = '0;
        i_imem_wdata = '0;
        timed_out    = 1'b0;
        cycles       = 0;
        build_program();
        // Load the program while reset is held
        for (int i = 0; i < prog.size(); i++) begin
            @(posedge i_clk);
            i_imem_we    <= 1'b1;
            i_imem_addr  <= 8'(i);
            i_imem_wdata <= prog[i];
        end
        @(posedge i_clk);
        i_imem_we <= 1'b0;
        repeat (8) @(posedge i_clk);
        i_reset <= 1'b1;
        // Wait for the last expected retirement
        while ((rows_done < N_ROWS) && !timed_out) begin
            @(posedge i_clk);
            cycles++;
            if (cycles >= TIMEOUT) begin
                timed_out = 1'b1;
            end
        end
        repeat (2) @(posedge i_clk);
        if (timed_out) begin
            $display("timeout waiting for retirement");
        end
        $display("retired rows: %0d, passed: %0d, errors: %0d", rows_done, pass_count,
                 err_count);
        if (!timed_out && (err_count == 0) && (rows_done == N_ROWS)) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
